/* cipher_ctrl.f */
+incdir+verilog
verilog/cipher_ctrl_pkg.sv
verilog/cipher_cfg_regs.sv
verilog/sp2v_sig_chk.sv
verilog/cipher_rail_fsm.sv
verilog/rail_combine.sv
verilog/cipher_ctrl.sv
tb/cipher_ctrl_chk.sv
tb/cipher_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the round controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f cipher_ctrl.f \
  --top-module cipher_ctrl_tb -o sim_cipher_ctrl

out=$(./obj_dir/sim_cipher_ctrl) || true
echo "$out"
if grep -qx "Test OK" <<< "$out"; then
  exit 0
fi
exit 1

/* tb/cipher_ctrl_chk.sv */
// Concurrent assertions bound to the round controller top level
// Handshake exclusion, sticky alert and legal sparse outputs

`timescale 1ns/1ps

module cipher_ctrl_chk (
  input logic                   clk_i,
  input logic                   rst_ni,
  input cipher_ctrl_pkg::sp2v_e in_ready_i,
  input cipher_ctrl_pkg::sp2v_e out_valid_i,
  input cipher_ctrl_pkg::sp2v_e state_we_i,
  input cipher_ctrl_pkg::sp2v_e sub_bytes_en_i,
  input logic                   alert_i
);

  function automatic bit is_legal(input cipher_ctrl_pkg::sp2v_e v);
    return (v == cipher_ctrl_pkg::SP2V_HIGH) || (v == cipher_ctrl_pkg::SP2V_LOW);
  endfunction

  no_accept_while_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(out_valid_i == cipher_ctrl_pkg::SP2V_HIGH && in_ready_i == cipher_ctrl_pkg::SP2V_HIGH))
    else $error("out_valid_o and in_ready_o both HIGH in one cycle");

  // Only reset clears the alert
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(alert_i) |-> alert_i)
    else $error("alert_o dropped without a reset");

  sparse_out_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    is_legal(in_ready_i) && is_legal(out_valid_i) &&
    is_legal(state_we_i) && is_legal(sub_bytes_en_i))
    else $error("illegal code on a sparse output");

endmodule

bind cipher_ctrl cipher_ctrl_chk u_chk (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .in_ready_i     ( in_ready_o     ),
  .out_valid_i    ( out_valid_o    ),
  .state_we_i     ( state_we_o     ),
  .sub_bytes_en_i ( sub_bytes_en_o ),
  .alert_i        ( alert_o        )
);

/* tb/cipher_ctrl_tb.sv */
// Testbench for the redundant AES round controller
// Clock and reset, stimulus read from the tests file, expected values
// from the round schedule, error injection and a watchdog

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl_tb;

  localparam int          MaxTests = 32;
  localparam int          Fields   = 5;  // op, key_len, sbox delay, stall, inject
  localparam logic [31:0] Seed     = 32'h61604b6c;
  localparam cipher_ctrl_pkg::sp2v_e Hi = cipher_ctrl_pkg::SP2V_HIGH;
  localparam cipher_ctrl_pkg::sp2v_e Lo = cipher_ctrl_pkg::SP2V_LOW;

  logic                         clk_i;
  logic                         rst_ni;
  cipher_ctrl_pkg::sp2v_e       in_valid_i, out_ready_i, sbox_req_i;
  cipher_ctrl_pkg::sp2v_e       in_ready_o, out_valid_o, sub_bytes_en_o, state_we_o;
  logic                         cfg_valid_i;
  cipher_ctrl_pkg::ciph_op_e    op_i, key_expand_op_o;
  cipher_ctrl_pkg::key_len_e    key_len_i;
  cipher_ctrl_pkg::state_sel_e  state_sel_o;
  cipher_ctrl_pkg::add_rk_sel_e add_rk_sel_o;
  logic [`RND_CTR_WIDTH-1:0]    key_expand_round_o;
  logic                         alert_o;

  logic [7:0] tests [MaxTests*Fields];
  int         num_tests;
  int         checks;
  int         errors;
  bit         loaded;

  cipher_ctrl uut (.*);

  always #20 clk_i = ~clk_i;  // 40 ns period

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic int rounds_for(input logic [1:0] klen);
    case (klen)
      2'b10:   return 12;
      2'b11:   return 14;
      default: return 10;  // 128 bit and unknown codes
    endcase
  endfunction

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic load_config(input logic op, input logic [1:0] klen);
    @(negedge clk_i);
    cfg_valid_i = 1'b1;
    op_i        = cipher_ctrl_pkg::ciph_op_e'(op);
    key_len_i   = cipher_ctrl_pkg::key_len_e'(klen);
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
    check("key_expand_op_o", key_expand_op_o, op);
  endtask

  // Illegal in_valid code, then alert until reset
  task automatic inject_error();
    logic [2:0] bad;
    do begin
      bad = 3'($urandom);
    end while (bad == `SP2V_HIGH || bad == `SP2V_LOW);
    @(negedge clk_i);
    check("alert_o", alert_o, 1'b0);
    in_valid_i = cipher_ctrl_pkg::sp2v_e'(bad);
    @(negedge clk_i);
    in_valid_i = Lo;
    repeat (4) begin
      #1;
      check("alert_o", alert_o, 1'b1);
      check("out_valid_o", out_valid_o, Lo);
      check("in_ready_o", in_ready_o, Lo);
      @(negedge clk_i);
    end
    apply_reset();
    #1;
    check("alert_o", alert_o, 1'b0);
    check("in_ready_o", in_ready_o, Hi);
  endtask

  task automatic run_block(input int nr, input int delay, input int stall);
    int writes;
    int cnt;
    bit seen_valid;
    bit released;
    writes     = 0;
    cnt        = 0;
    seen_valid = 1'b0;
    released   = 1'b0;
    @(negedge clk_i);
    check("in_ready_o", in_ready_o, Hi);
    in_valid_i = Hi;
    @(negedge clk_i);
    in_valid_i = Lo;
    while (!released) begin
      // S-box answers every delay+1 cycles while enabled
      if (sub_bytes_en_o == Hi) begin
        sbox_req_i = (cnt == delay) ? Hi : Lo;
        cnt        = (cnt == delay) ? 0 : cnt + 1;
      end else begin
        sbox_req_i = Lo;
      end
      out_ready_i = (stall == 0) ? Hi : Lo;
      #1;
      check("in_ready_o", in_ready_o, Lo);
      // Enabled from the first round until the last S-box result
      check("sub_bytes_en_o", sub_bytes_en_o, (writes >= 1 && !seen_valid) ? Hi : Lo);
      if (state_we_o == Hi) begin
        check("key_expand_round_o", key_expand_round_o, writes);
        check("state_sel_o", state_sel_o, (writes == 0) ? cipher_ctrl_pkg::STATE_INIT :
                                                           cipher_ctrl_pkg::STATE_ROUND);
        check("add_rk_sel_o", add_rk_sel_o,
              (writes == 0)  ? cipher_ctrl_pkg::ADD_RK_INIT :
              (writes == nr) ? cipher_ctrl_pkg::ADD_RK_FINAL : cipher_ctrl_pkg::ADD_RK_ROUND);
        writes++;
      end
      if (out_valid_o == Hi) begin
        seen_valid = 1'b1;
        if (out_ready_i == Hi) released = 1'b1;
        else stall--;
      end else if (seen_valid) begin
        check("out_valid_o", out_valid_o, Hi);  // Dropped under back-pressure
      end
      @(negedge clk_i);
    end
    sbox_req_i  = Lo;
    out_ready_i = Lo;
    #1;
    check("write cycles", writes, nr + 1);
    check("out_valid_o", out_valid_o, Lo);
    check("sub_bytes_en_o", sub_bytes_en_o, Lo);
    check("in_ready_o", in_ready_o, Hi);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int base;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    in_valid_i  = Lo;
    out_ready_i = Lo;
    sbox_req_i  = Lo;
    cfg_valid_i = 1'b0;
    op_i        = cipher_ctrl_pkg::CIPH_FWD;
    key_len_i   = cipher_ctrl_pkg::AES_128;
    checks      = 0;
    errors      = 0;
    void'($urandom(Seed));
    for (int i = 0; i < MaxTests*Fields; i++) tests[i] = 8'hff;  // End marker
    $readmemh("tb/cipher_ctrl_tests.txt", tests);
    num_tests = 0;
    while (num_tests < MaxTests && tests[num_tests*Fields] != 8'hff) num_tests++;
    if (num_tests == 0) begin
      $display("No tests were read from the stimulus file");
      errors++;
    end
    loaded = 1'b1;

    apply_reset();
    #1;
    check("in_ready_o", in_ready_o, Hi);
    check("out_valid_o", out_valid_o, Lo);
    check("alert_o", alert_o, 1'b0);

    for (int t = 0; t < num_tests; t++) begin
      base = t * Fields;
      if (tests[base+4] != 8'h0) inject_error();
      load_config(tests[base][0], tests[base+1][1:0]);
      run_block(rounds_for(tests[base+1][1:0]), tests[base+2],
                tests[base+3] + int'($urandom % 3));  // Stall jitter
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded && num_tests > 0);
    repeat (num_tests * 200) @(posedge clk_i);
    $display("Watchdog expired before all tests finished");
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* tb/cipher_ctrl_tests.txt */
// Columns (hex): op key_len sbox_delay out_stall inject
// key_len 1, 2, 3 select 128, 192, 256 bit keys, 0 is an unknown code
0 1 0 0 0
1 1 2 3 0
0 2 1 5 0
1 3 0 1 0
0 3 3 0 0
1 0 1 2 0
0 2 0 4 1
1 1 1 0 1
0 3 2 7 0

/* verilog/cipher_cfg_regs.sv */
// Configuration register of the round controller
// Latches operation and key length, turns key length into a round count

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_cfg_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         cfg_valid_i,
  input  cipher_ctrl_pkg::ciph_op_e    op_i,
  input  cipher_ctrl_pkg::key_len_e    key_len_i,
  output cipher_ctrl_pkg::ciph_op_e    op_o,
  output logic [`RND_CTR_WIDTH-1:0]    num_rounds_o
);

  logic [`RND_CTR_WIDTH-1:0] num_rounds_d;

  always_comb begin : key_len_decode
    case (key_len_i)
      cipher_ctrl_pkg::AES_192: num_rounds_d = `NR_192;
      cipher_ctrl_pkg::AES_256: num_rounds_d = `NR_256;
      default:                  num_rounds_d = `NR_128;  // Also unknown codes
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : cfg_reg
    if (!rst_ni) begin
      op_o         <= cipher_ctrl_pkg::CIPH_FWD;
      num_rounds_o <= `NR_128;
    end else if (cfg_valid_i) begin
      op_o         <= op_i;
      num_rounds_o <= num_rounds_d;
    end
  end

endmodule

/* verilog/cipher_ctrl.sv */
// Redundant AES round controller, top level
// Config register, sparse input check, one FSM rail per encoding bit
// and combiners for selects and alert

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  cipher_ctrl_pkg::sp2v_e        in_valid_i,
  output cipher_ctrl_pkg::sp2v_e        in_ready_o,
  output cipher_ctrl_pkg::sp2v_e        out_valid_o,
  input  cipher_ctrl_pkg::sp2v_e        out_ready_i,
  input  logic                          cfg_valid_i,
  input  cipher_ctrl_pkg::ciph_op_e     op_i,
  input  cipher_ctrl_pkg::key_len_e     key_len_i,
  input  cipher_ctrl_pkg::sp2v_e        sbox_req_i,
  output cipher_ctrl_pkg::sp2v_e        sub_bytes_en_o,
  output cipher_ctrl_pkg::sp2v_e        state_we_o,
  output cipher_ctrl_pkg::state_sel_e   state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e  add_rk_sel_o,
  output cipher_ctrl_pkg::ciph_op_e     key_expand_op_o,
  output logic [`RND_CTR_WIDTH-1:0]     key_expand_round_o,
  output logic                          alert_o
);

  localparam logic [`SP2V_WIDTH-1:0] HighCode = `SP2V_HIGH;

  logic [`RND_CTR_WIDTH-1:0]                       num_rounds;
  cipher_ctrl_pkg::sp2v_e [`NUM_SP2V_IN-1:0]       sp_in;
  logic [`NUM_SP2V_IN-1:0][`SP2V_WIDTH-1:0]        sp_bits;  // [signal][rail]
  logic                                            enc_err;
  logic                                            mr_err;
  logic [`SP2V_WIDTH-1:0]  sp_in_ready, sp_out_valid, sp_state_we, sp_sub_bytes_en;
  cipher_ctrl_pkg::ctrl_sel_t                      mr_sel [`SP2V_WIDTH];
  cipher_ctrl_pkg::ctrl_sel_t                      sel;
  logic                                            mr_alert [`SP2V_WIDTH];

  cipher_cfg_regs u_cfg_regs (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .cfg_valid_i  ( cfg_valid_i     ),
    .op_i         ( op_i            ),
    .key_len_i    ( key_len_i       ),
    .op_o         ( key_expand_op_o ),
    .num_rounds_o ( num_rounds      )
  );

  assign sp_in[0] = in_valid_i;
  assign sp_in[1] = out_ready_i;
  assign sp_in[2] = sbox_req_i;

  sp2v_sig_chk #(.NumSig(`NUM_SP2V_IN)) u_sig_chk (
    .sig_i  ( sp_in   ),
    .bits_o ( sp_bits ),
    .err_o  ( enc_err )
  );

  //////////////////////////////////////////////////
  // One FSM rail per encoding bit
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `SP2V_WIDTH; i++) begin : gen_rail
    cipher_rail_fsm #(.Inverted(~HighCode[i])) u_rail (
      .clk_i          ( clk_i              ),
      .rst_ni         ( rst_ni             ),
      .in_valid_i     ( sp_bits[0][i]      ),
      .out_ready_i    ( sp_bits[1][i]      ),
      .sbox_req_i     ( sp_bits[2][i]      ),
      .num_rounds_i   ( num_rounds         ),
      .enc_err_i      ( enc_err            ),
      .mr_err_i       ( mr_err             ),
      .in_ready_o     ( sp_in_ready[i]     ),
      .out_valid_o    ( sp_out_valid[i]    ),
      .state_we_o     ( sp_state_we[i]     ),
      .sub_bytes_en_o ( sp_sub_bytes_en[i] ),
      .sel_o          ( mr_sel[i]          ),
      .alert_o        ( mr_alert[i]        )
    );
  end

  rail_combine #(.T(cipher_ctrl_pkg::ctrl_sel_t), .NumRails(`SP2V_WIDTH)) u_sel_comb (
    .rails_i    ( mr_sel ),
    .comb_o     ( sel    ),
    .mismatch_o ( mr_err )
  );

  rail_combine #(.T(logic), .NumRails(`SP2V_WIDTH)) u_alert_comb (
    .rails_i    ( mr_alert ),
    .comb_o     ( alert_o  ),
    .mismatch_o (          )
  );

  // Reassemble sparse outputs from rail bits
  assign in_ready_o         = cipher_ctrl_pkg::sp2v_e'(sp_in_ready);
  assign out_valid_o        = cipher_ctrl_pkg::sp2v_e'(sp_out_valid);
  assign state_we_o         = cipher_ctrl_pkg::sp2v_e'(sp_state_we);
  assign sub_bytes_en_o     = cipher_ctrl_pkg::sp2v_e'(sp_sub_bytes_en);
  assign state_sel_o        = sel.state_sel;
  assign add_rk_sel_o       = sel.add_rk_sel;
  assign key_expand_round_o = sel.rnd_ctr;

endmodule

/* verilog/cipher_ctrl_consts.svh */
// Shared constants of the round controller
// Sparse two-value encoding, select widths and round counts

`ifndef CIPHER_CTRL_CONSTS_SVH
`define CIPHER_CTRL_CONSTS_SVH

//////////////////////////////////////////////////
// Sparse two-value encoding
//////////////////////////////////////////////////

`define SP2V_WIDTH        3
`define SP2V_HIGH         3'b011
`define SP2V_LOW          3'b100   // Bitwise complement of HIGH
`define NUM_SP2V_IN       3        // in_valid, out_ready, sbox_req

//////////////////////////////////////////////////
// Widths and round counts
//////////////////////////////////////////////////

`define STATE_SEL_WIDTH   3
`define ADD_RK_SEL_WIDTH  3
`define KEY_LEN_WIDTH     2
`define RAIL_ST_WIDTH     5
`define RND_CTR_WIDTH     4

`define NR_128            4'd10
`define NR_192            4'd12
`define NR_256            4'd14

`endif

/* verilog/cipher_ctrl_pkg.sv */
// Types of the round controller
// Sparse level enum, configuration enums, select enums, rail FSM states
// and the select struct compared across rails

`include "cipher_ctrl_consts.svh"

package cipher_ctrl_pkg;

  typedef enum logic [`SP2V_WIDTH-1:0] {
    SP2V_HIGH = `SP2V_HIGH,
    SP2V_LOW  = `SP2V_LOW
  } sp2v_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [`KEY_LEN_WIDTH-1:0] {
    AES_128 = 2'b01,
    AES_192 = 2'b10,
    AES_256 = 2'b11
  } key_len_e;

  // State register input mux, pairwise distance 2
  typedef enum logic [`STATE_SEL_WIDTH-1:0] {
    STATE_HOLD  = 3'b011,
    STATE_INIT  = 3'b101,
    STATE_ROUND = 3'b110
  } state_sel_e;

  typedef enum logic [`ADD_RK_SEL_WIDTH-1:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  // Rail FSM states, at least 2 bits apart
  typedef enum logic [`RAIL_ST_WIDTH-1:0] {
    ST_IDLE   = 5'b00111,
    ST_INIT   = 5'b11001,
    ST_ROUND  = 5'b01010,
    ST_FINISH = 5'b10100,
    ST_ERROR  = 5'b11110
  } rail_state_e;

  typedef struct packed {
    state_sel_e                state_sel;
    add_rk_sel_e               add_rk_sel;
    logic [`RND_CTR_WIDTH-1:0] rnd_ctr;
  } ctrl_sel_t;

endpackage

/* verilog/cipher_rail_fsm.sv */
// One rail of the redundant round control FSM
// States IDLE, INIT, ROUND, FINISH and ERROR with a private round counter
// Sparse inputs and outputs are single bits at the rail polarity

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_rail_fsm #(
  parameter bit Inverted = 1'b0  // Set where the HIGH code has a 0 in this bit
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        in_valid_i,
  input  logic                        out_ready_i,
  input  logic                        sbox_req_i,
  input  logic [`RND_CTR_WIDTH-1:0]   num_rounds_i,
  input  logic                        enc_err_i,
  input  logic                        mr_err_i,
  output logic                        in_ready_o,
  output logic                        out_valid_o,
  output logic                        state_we_o,
  output logic                        sub_bytes_en_o,
  output cipher_ctrl_pkg::ctrl_sel_t  sel_o,
  output logic                        alert_o
);

  cipher_ctrl_pkg::rail_state_e state_d, state_q, state_nom;
  logic [`RND_CTR_WIDTH-1:0]    rnd_ctr_d, rnd_ctr_q;
  logic                         done_d, done_q;  // S-box result seen in FINISH

  // Active-high views of the rail bits
  logic in_valid, out_ready, sbox_req;
  logic in_ready, out_valid, state_we, sub_bytes_en;

  assign in_valid  = in_valid_i  ^ Inverted;
  assign out_ready = out_ready_i ^ Inverted;
  assign sbox_req  = sbox_req_i  ^ Inverted;

  //////////////////////////////////////////////////
  // Outputs and nominal next state
  //////////////////////////////////////////////////

  always_comb begin : fsm_comb
    state_nom        = state_q;
    rnd_ctr_d        = rnd_ctr_q;
    done_d           = done_q;
    in_ready         = 1'b0;
    out_valid        = 1'b0;
    state_we         = 1'b0;
    sub_bytes_en     = 1'b0;
    alert_o          = 1'b0;
    sel_o.state_sel  = cipher_ctrl_pkg::STATE_HOLD;
    sel_o.add_rk_sel = cipher_ctrl_pkg::ADD_RK_INIT;
    sel_o.rnd_ctr    = rnd_ctr_q;

    case (state_q)
      cipher_ctrl_pkg::ST_IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          rnd_ctr_d = '0;
          state_nom = cipher_ctrl_pkg::ST_INIT;
        end
      end

      // Initial key addition, round 0
      cipher_ctrl_pkg::ST_INIT: begin
        state_we        = 1'b1;
        sel_o.state_sel = cipher_ctrl_pkg::STATE_INIT;
        rnd_ctr_d       = rnd_ctr_q + 1'b1;
        state_nom       = cipher_ctrl_pkg::ST_ROUND;
      end

      cipher_ctrl_pkg::ST_ROUND: begin
        sub_bytes_en     = 1'b1;
        sel_o.add_rk_sel = cipher_ctrl_pkg::ADD_RK_ROUND;
        if (sbox_req) begin
          state_we        = 1'b1;
          sel_o.state_sel = cipher_ctrl_pkg::STATE_ROUND;
          rnd_ctr_d       = rnd_ctr_q + 1'b1;
          if (rnd_ctr_d == num_rounds_i) begin
            state_nom = cipher_ctrl_pkg::ST_FINISH;  // Last round left
          end
        end
      end

      cipher_ctrl_pkg::ST_FINISH: begin
        sel_o.add_rk_sel = cipher_ctrl_pkg::ADD_RK_FINAL;
        sub_bytes_en     = ~done_q;
        out_valid        = sbox_req | done_q;
        if (out_valid && out_ready) begin
          state_we        = 1'b1;
          sel_o.state_sel = cipher_ctrl_pkg::STATE_ROUND;
          rnd_ctr_d       = '0;
          done_d          = 1'b0;
          state_nom       = cipher_ctrl_pkg::ST_IDLE;
        end else if (sbox_req) begin
          done_d = 1'b1;  // Hold the result under back-pressure
        end
      end

      // Terminal, left only through reset
      cipher_ctrl_pkg::ST_ERROR: alert_o = 1'b1;

      default: begin
        alert_o   = 1'b1;
        state_nom = cipher_ctrl_pkg::ST_ERROR;
      end
    endcase
  end

  // Errors override whatever the rail would do next
  assign state_d = (enc_err_i || mr_err_i) ? cipher_ctrl_pkg::ST_ERROR : state_nom;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      state_q   <= cipher_ctrl_pkg::ST_IDLE;
      rnd_ctr_q <= '0;
      done_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      done_q    <= done_d;
    end
  end

  // Back to rail polarity, inactive gives the LOW bit
  assign in_ready_o     = in_ready     ^ Inverted;
  assign out_valid_o    = out_valid    ^ Inverted;
  assign state_we_o     = state_we     ^ Inverted;
  assign sub_bytes_en_o = sub_bytes_en ^ Inverted;

endmodule

/* verilog/rail_combine.sv */
// OR-combiner for multi-rail outputs
// Flags a mismatch when any rail differs from the combined value

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module rail_combine #(
  parameter type T        = logic,
  parameter int  NumRails = `SP2V_WIDTH
) (
  input  T     rails_i [NumRails],
  output T     comb_o,
  output logic mismatch_o
);

  always_comb begin : or_comb
    comb_o = T'(0);
    for (int i = 0; i < NumRails; i++) begin
      comb_o = T'(comb_o | rails_i[i]);
    end
  end

  // A faulty rail that still yields a legal OR is caught here
  always_comb begin : mismatch_chk
    mismatch_o = 1'b0;
    for (int i = 0; i < NumRails; i++) begin
      if (rails_i[i] != comb_o) begin
        mismatch_o = 1'b1;
      end
    end
  end

endmodule

/* verilog/sp2v_sig_chk.sv */
// Legality check for a vector of sparse two-value signals
// Passes the raw bits on and flags any code that is neither HIGH nor LOW

`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module sp2v_sig_chk #(
  parameter int NumSig = `NUM_SP2V_IN
) (
  input  cipher_ctrl_pkg::sp2v_e [NumSig-1:0]          sig_i,
  output logic [NumSig-1:0][`SP2V_WIDTH-1:0]           bits_o,
  output logic                                         err_o
);

  logic [NumSig-1:0] sig_err;

  //////////////////////////////////////////////////
  // Per-signal check
  //////////////////////////////////////////////////

  always_comb begin : chk
    for (int i = 0; i < NumSig; i++) begin
      bits_o[i] = sig_i[i];
      // Legal only when matching one of the two codes exactly
      sig_err[i] = (sig_i[i] != cipher_ctrl_pkg::SP2V_HIGH) &&
                   (sig_i[i] != cipher_ctrl_pkg::SP2V_LOW);
    end
  end

  assign err_o = |sig_err;  // Any single violation is fatal

endmodule
